// File: afu_cmd_top.f
src/cmd_pkg.sv
src/croom_ctrl.sv
src/cmd_fifo.sv
src/tag_mgr.sv
src/cmd_issue.sv
src/afu_cmd_top.sv
testbench/tb_afu_cmd_top.sv

// File: run.sh
#!/bin/sh
# build and run the command pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_afu_cmd_top -f afu_cmd_top.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation ok"

// File: src/afu_cmd_top.sv
//----------------------------------------------------------------------------
// command intake pipeline top
// credit check, command FIFO, tag allocation and issue stage
//----------------------------------------------------------------------------
`timescale 1ns/1ns

module afu_cmd_top #(
   parameter int FIFO_DEPTH = cmd_pkg::DEF_FIFO_DEPTH
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_db_v,
   input  cmd_pkg::ctxt_t  i_db_ctxt,
   input  cmd_pkg::ea_t    i_db_ea,
   input  cmd_pkg::croom_t i_croom_max,
   input  logic            i_ctxt_rst_v,
   input  cmd_pkg::ctxt_t  i_ctxt_rst_id,
   output logic            o_ctxt_rst_ack,
   output logic            o_croom_err_v,
   output cmd_pkg::ctxt_t  o_croom_err_ctxt,
   output logic            o_cmd_dropped,
   input  logic            i_cmpl_v,
   input  cmd_pkg::tag_t   i_cmpl_tag,
   output logic            o_no_tags,
   output logic            o_cmpl_error_hld,
   output logic            o_cmd_v,
   input  logic            i_cmd_r,
   output cmd_pkg::ctxt_t  o_cmd_ctxt,
   output cmd_pkg::ea_t    o_cmd_ea,
   output cmd_pkg::tag_t   o_cmd_tag,
   output logic            o_cmd_ok
);
   import cmd_pkg::*;

   localparam int FIFO_W = CTXT_W + EA_W;

   logic              push_v, push_r;
   ctxt_t             push_ctxt;
   ea_t               push_ea;
   logic              head_v, head_r;
   logic [FIFO_W-1:0] head_d;
   logic              tag_v, tag_alloc;
   tag_t              tag_free;
   logic              dec_v;

   // credit goes back when the command leaves the block
   assign dec_v = o_cmd_v & i_cmd_r;

   croom_ctrl u_croom (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_db_v           (i_db_v),
      .i_db_ctxt        (i_db_ctxt),
      .i_db_ea          (i_db_ea),
      .i_croom_max      (i_croom_max),
      .i_ctxt_rst_v     (i_ctxt_rst_v),
      .i_ctxt_rst_id    (i_ctxt_rst_id),
      .o_ctxt_rst_ack   (o_ctxt_rst_ack),
      .i_dec_v          (dec_v),
      .i_dec_ctxt       (o_cmd_ctxt),
      .o_push_v         (push_v),
      .i_push_r         (push_r),
      .o_push_ctxt      (push_ctxt),
      .o_push_ea        (push_ea),
      .o_croom_err_v    (o_croom_err_v),
      .o_croom_err_ctxt (o_croom_err_ctxt),
      .o_cmd_dropped    (o_cmd_dropped)
   );

   cmd_fifo #(
      .DATA_W     (FIFO_W),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_v     (push_v),
      .o_r     (push_r),
      .i_d     ({push_ctxt, push_ea}),   // context on top, address below
      .o_v     (head_v),
      .i_r     (head_r),
      .o_d     (head_d)
   );

   tag_mgr u_tags (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .o_avail_v        (tag_v),
      .o_avail_tag      (tag_free),
      .i_alloc          (tag_alloc),
      .i_cmpl_v         (i_cmpl_v),
      .i_cmpl_tag       (i_cmpl_tag),
      .o_no_tags        (o_no_tags),
      .o_cmpl_error_hld (o_cmpl_error_hld)
   );

   cmd_issue u_issue (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_head_v    (head_v),
      .o_head_r    (head_r),
      .i_head_ctxt (head_d[FIFO_W-1 -: CTXT_W]),
      .i_head_ea   (head_d[EA_W-1:0]),
      .i_tag_v     (tag_v),
      .i_tag       (tag_free),
      .o_alloc     (tag_alloc),
      .o_cmd_v     (o_cmd_v),
      .i_cmd_r     (i_cmd_r),
      .o_cmd_ctxt  (o_cmd_ctxt),
      .o_cmd_ea    (o_cmd_ea),
      .o_cmd_tag   (o_cmd_tag),
      .o_cmd_ok    (o_cmd_ok)
   );

endmodule

// File: src/cmd_fifo.sv
//----------------------------------------------------------------------------
// show-ahead synchronous FIFO, valid/ready on write and read side
//----------------------------------------------------------------------------
`timescale 1ns/1ns

module cmd_fifo #(
   parameter int DATA_W     = cmd_pkg::CTXT_W + cmd_pkg::EA_W,
   parameter int FIFO_DEPTH = cmd_pkg::DEF_FIFO_DEPTH
) (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_v,
   output logic              o_r,
   input  logic [DATA_W-1:0] i_d,
   output logic              o_v,
   input  logic              i_r,
   output logic [DATA_W-1:0] o_d
);
   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [DATA_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0]  count_q;
   logic              push, pop;

   assign o_r  = count_q != CNT_W'(FIFO_DEPTH);
   assign o_v  = count_q != '0;
   assign push = i_v & o_r;
   assign pop  = o_v & i_r;
   assign o_d  = mem[rd_ptr_q];                   // head shows without a pop

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         if (push && !pop) count_q <= count_q + 1'b1;
         else if (pop && !push) count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr_q] <= i_d;
   end

   // full stays full unless something drains
   a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
      (count_q == CNT_W'(FIFO_DEPTH) && !pop) |=> count_q == CNT_W'(FIFO_DEPTH));

   // an empty FIFO can only grow
   a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
      (count_q == '0) |=> count_q <= CNT_W'(1));

endmodule

// File: src/cmd_issue.sv
//----------------------------------------------------------------------------
// command issue stage
// joins queue head with a free tag, flags misaligned blocks, holds output
//----------------------------------------------------------------------------
`timescale 1ns/1ns

module cmd_issue (
   input  logic           clk,
   input  logic           i_rst_n,
   input  logic           i_head_v,
   output logic           o_head_r,
   input  cmd_pkg::ctxt_t i_head_ctxt,
   input  cmd_pkg::ea_t   i_head_ea,
   input  logic           i_tag_v,
   input  cmd_pkg::tag_t  i_tag,
   output logic           o_alloc,
   output logic           o_cmd_v,
   input  logic           i_cmd_r,
   output cmd_pkg::ctxt_t o_cmd_ctxt,
   output cmd_pkg::ea_t   o_cmd_ea,
   output cmd_pkg::tag_t  o_cmd_tag,
   output logic           o_cmd_ok
);
   import cmd_pkg::*;

   logic  out_v_q;
   ctxt_t out_ctxt_q;
   ea_t   out_ea_q;
   tag_t  out_tag_q;
   logic  out_ok_q;
   logic  slot_free;
   logic  load;
   logic  head_aligned;

   assign slot_free    = ~out_v_q | i_cmd_r;    // empty or draining this cycle
   assign load         = i_head_v & i_tag_v & slot_free;
   assign head_aligned = ~|i_head_ea[ALIGN_BITS-1:0];

   assign o_head_r = i_tag_v & slot_free;
   assign o_alloc  = load;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_v_q <= 1'b0;
      end else if (load) begin
         out_v_q <= 1'b1;
      end else if (i_cmd_r) begin
         out_v_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         out_ctxt_q <= i_head_ctxt;
         out_ea_q   <= i_head_ea;
         out_tag_q  <= i_tag;
         out_ok_q   <= head_aligned;   // misaligned still goes out, ok low
      end
   end

   assign o_cmd_v    = out_v_q;
   assign o_cmd_ctxt = out_ctxt_q;
   assign o_cmd_ea   = out_ea_q;
   assign o_cmd_tag  = out_tag_q;
   assign o_cmd_ok   = out_ok_q;

   // stalled command holds still until the consumer takes it
   a_stall_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_cmd_v && !i_cmd_r) |=> o_cmd_v && $stable(o_cmd_ctxt) && $stable(o_cmd_ea)
                                && $stable(o_cmd_tag) && $stable(o_cmd_ok));

endmodule

// File: src/cmd_pkg.sv
//----------------------------------------------------------------------------
// command intake pipeline shared widths and vector types
// sizes for contexts, addresses, tags and command-room credits
//----------------------------------------------------------------------------
package cmd_pkg;

   localparam int CTXT_W   = 4;
   localparam int NUM_CTXT = 2 ** CTXT_W;
   localparam int EA_W     = 64;        // effective address of the request block
   localparam int TAG_W    = 4;
   localparam int NUM_TAGS = 16;
   localparam int CROOM_W  = 8;         // credit counter and room limit

   // low address bits that have to be zero, 16-byte alignment
   localparam int ALIGN_BITS = 4;

   localparam int DEF_FIFO_DEPTH = 8;

   typedef logic [CTXT_W-1:0]  ctxt_t;
   typedef logic [EA_W-1:0]    ea_t;
   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [CROOM_W-1:0] croom_t;

endpackage

// File: src/croom_ctrl.sv
//----------------------------------------------------------------------------
// per-context command-room credits
// sorts each doorbell into accept, reject or drop and keeps outstanding counts
//----------------------------------------------------------------------------
`timescale 1ns/1ns

module croom_ctrl (
   input  logic           clk,
   input  logic           i_rst_n,
   input  logic           i_db_v,
   input  cmd_pkg::ctxt_t i_db_ctxt,
   input  cmd_pkg::ea_t   i_db_ea,
   input  cmd_pkg::croom_t i_croom_max,
   input  logic           i_ctxt_rst_v,
   input  cmd_pkg::ctxt_t i_ctxt_rst_id,
   output logic           o_ctxt_rst_ack,
   input  logic           i_dec_v,
   input  cmd_pkg::ctxt_t i_dec_ctxt,
   output logic           o_push_v,
   input  logic           i_push_r,
   output cmd_pkg::ctxt_t o_push_ctxt,
   output cmd_pkg::ea_t   o_push_ea,
   output logic           o_croom_err_v,
   output cmd_pkg::ctxt_t o_croom_err_ctxt,
   output logic           o_cmd_dropped
);
   import cmd_pkg::*;

   croom_t               cnt_q [NUM_CTXT];
   logic [NUM_CTXT-1:0]  inc_hit, dec_hit, rst_hit;
   logic                 acc_q, rej_q;       // registered doorbell outcome
   ctxt_t                db_ctxt_q;
   ea_t                  db_ea_q;
   logic                 ack_q;
   logic                 push_fire;
   logic                 pend_same;
   logic [CROOM_W:0]     db_level;
   logic                 db_room;

   assign push_fire = acc_q & i_push_r;

   // a push still in flight for the same context counts against its room
   assign pend_same = push_fire & (db_ctxt_q == i_db_ctxt);
   assign db_level  = {1'b0, cnt_q[i_db_ctxt]} + {{CROOM_W{1'b0}}, pend_same};
   assign db_room   = db_level < {1'b0, i_croom_max};

   always_comb begin
      for (int i = 0; i < NUM_CTXT; i++) begin
         inc_hit[i] = push_fire & (db_ctxt_q == ctxt_t'(i));
         dec_hit[i] = i_dec_v & (i_dec_ctxt == ctxt_t'(i));
         rst_hit[i] = i_ctxt_rst_v & (i_ctxt_rst_id == ctxt_t'(i));
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt_q <= '{default: '0};
      end else begin
         for (int i = 0; i < NUM_CTXT; i++) begin
            if (rst_hit[i]) begin
               cnt_q[i] <= '0;                        // context reset wins
            end else if (inc_hit[i] && !dec_hit[i]) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end else if (dec_hit[i] && !inc_hit[i] && cnt_q[i] != '0) begin
               cnt_q[i] <= cnt_q[i] - 1'b1;           // saturate at zero
            end
         end
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         acc_q <= 1'b0;
         rej_q <= 1'b0;
         ack_q <= 1'b0;
      end else begin
         acc_q <= i_db_v & db_room;
         rej_q <= i_db_v & ~db_room;
         ack_q <= i_ctxt_rst_v;
      end
   end

   always_ff @(posedge clk) begin
      if (i_db_v) begin
         db_ctxt_q <= i_db_ctxt;
         db_ea_q   <= i_db_ea;
      end
   end

   // no back-pressure on the doorbell, a full FIFO means the command is lost
   assign o_push_v         = push_fire;
   assign o_push_ctxt      = db_ctxt_q;
   assign o_push_ea        = db_ea_q;
   assign o_cmd_dropped    = acc_q & ~i_push_r;
   assign o_croom_err_v    = rej_q;
   assign o_croom_err_ctxt = db_ctxt_q;
   assign o_ctxt_rst_ack   = ack_q;

   // the room check made at doorbell time still holds when the count moves
   a_room_limit: assert property (@(posedge clk) disable iff (!i_rst_n)
      push_fire |=> cnt_q[$past(db_ctxt_q)] <= $past(i_croom_max));

endmodule

// File: src/tag_mgr.sv
//----------------------------------------------------------------------------
// command tag free list
// hands out the lowest free tag, takes completions, flags bad frees
//----------------------------------------------------------------------------
`timescale 1ns/1ns

module tag_mgr (
   input  logic          clk,
   input  logic          i_rst_n,
   output logic          o_avail_v,
   output cmd_pkg::tag_t o_avail_tag,
   input  logic          i_alloc,
   input  logic          i_cmpl_v,
   input  cmd_pkg::tag_t i_cmpl_tag,
   output logic          o_no_tags,
   output logic          o_cmpl_error_hld
);
   import cmd_pkg::*;

   logic [NUM_TAGS-1:0] outst_q;       // one bit per tag in flight
   logic [NUM_TAGS-1:0] set_vec, clr_vec;
   tag_t                free_tag;
   logic                bad_free;
   logic                err_q;

   // priority pick where the lowest index wins
   always_comb begin
      free_tag = '0;
      for (int i = NUM_TAGS - 1; i >= 0; i--) begin
         if (!outst_q[i]) begin
            free_tag = tag_t'(i);
         end
      end
   end

   assign o_avail_v   = ~&outst_q;
   assign o_avail_tag = free_tag;
   assign o_no_tags   = &outst_q;

   assign bad_free = i_cmpl_v & ~outst_q[i_cmpl_tag];

   always_comb begin
      set_vec = '0;
      clr_vec = '0;
      if (i_alloc) begin
         set_vec[free_tag] = 1'b1;
      end
      if (i_cmpl_v) begin
         clr_vec[i_cmpl_tag] = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         outst_q <= '0;
      end else begin
         outst_q <= (outst_q & ~clr_vec) | set_vec;
      end
   end

   // sticky until reset
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         err_q <= 1'b0;
      end else if (bad_free) begin
         err_q <= 1'b1;
      end
   end

   assign o_cmpl_error_hld = err_q;

   // the issue stage only allocates what is offered, and that tag is free
   a_alloc_free: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_alloc |-> o_avail_v && !outst_q[o_avail_tag]);

endmodule

// File: testbench/tb_afu_cmd_top.sv
//----------------------------------------------------------------------------
// testbench for the command intake pipeline
// reference model of credits, command order and tags with a cycle checker
//----------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_afu_cmd_top;
   import cmd_pkg::*;

   localparam int CYC_LIMIT = 4000;   // several times what reset and the six phases need

   logic   clk;
   logic   i_rst_n;
   logic   db_v, rst_v, cmpl_v, cmd_r;
   ctxt_t  db_ctxt, rst_id;
   ea_t    db_ea;
   croom_t croom_max;
   tag_t   cmpl_tag;
   logic   o_ctxt_rst_ack, o_croom_err_v, o_cmd_dropped, o_no_tags, o_cmpl_error_hld;
   logic   o_cmd_v, o_cmd_ok;
   ctxt_t  o_croom_err_ctxt, o_cmd_ctxt;
   ea_t    o_cmd_ea;
   tag_t   o_cmd_tag;

   // reference state
   int     mcnt [NUM_CTXT];
   ctxt_t  exp_ctxt_q [$];
   ea_t    exp_ea_q [$];
   bit     outst [NUM_TAGS];
   bit     prev_db_v, prev_acc, prev_rst, err_exp;
   ctxt_t  prev_ctxt;
   ea_t    prev_ea;
   int     n_db, n_acc, n_rej, n_drop, n_iss, cyc;
   int     base_rej, base_acc, base_iss;
   bit     pushed_now, hs, acc_now;

   afu_cmd_top #(.FIFO_DEPTH(DEF_FIFO_DEPTH)) i_dut (
      .clk (clk), .i_rst_n (i_rst_n),
      .i_db_v (db_v), .i_db_ctxt (db_ctxt), .i_db_ea (db_ea),
      .i_croom_max (croom_max),
      .i_ctxt_rst_v (rst_v), .i_ctxt_rst_id (rst_id), .o_ctxt_rst_ack (o_ctxt_rst_ack),
      .o_croom_err_v (o_croom_err_v), .o_croom_err_ctxt (o_croom_err_ctxt),
      .o_cmd_dropped (o_cmd_dropped),
      .i_cmpl_v (cmpl_v), .i_cmpl_tag (cmpl_tag),
      .o_no_tags (o_no_tags), .o_cmpl_error_hld (o_cmpl_error_hld),
      .o_cmd_v (o_cmd_v), .i_cmd_r (cmd_r), .o_cmd_ctxt (o_cmd_ctxt),
      .o_cmd_ea (o_cmd_ea), .o_cmd_tag (o_cmd_tag), .o_cmd_ok (o_cmd_ok)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // doorbell accepted when outstanding level is below the room limit
   function automatic bit exp_accept(input int level, input croom_t max);
      return level < int'(max);
   endfunction

   function automatic bit exp_ok(input ea_t ea);
      return ea[ALIGN_BITS-1:0] == '0;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
         stop_run("value mismatch");
      end
   endtask

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= CYC_LIMIT) stop_run("timeout, the run did not finish in time");
   end

   // compare process samples the values that were set before this edge
   always @(posedge clk) begin
      if (i_rst_n) begin
         pushed_now = 1'b0;
         acc_now    = 1'b0;
         hs         = o_cmd_v & cmd_r;
         if (hs) begin
            if (exp_ctxt_q.size() == 0) stop_run("command issued with nothing expected");
            check("o_cmd_ctxt", o_cmd_ctxt, exp_ctxt_q[0]);
            check("o_cmd_ea", o_cmd_ea, exp_ea_q[0]);
            check("o_cmd_ok", o_cmd_ok, exp_ok(exp_ea_q[0]));
            check("o_cmd_tag busy", outst[o_cmd_tag], 0);
            outst[o_cmd_tag] = 1'b1;
            void'(exp_ctxt_q.pop_front());
            void'(exp_ea_q.pop_front());
            n_iss++;
         end
         if (prev_db_v && prev_acc) begin
            check("o_croom_err_v", o_croom_err_v, 0);
            if (o_cmd_dropped) begin
               n_drop++;
            end else begin
               pushed_now = 1'b1;
               exp_ctxt_q.push_back(prev_ctxt);
               exp_ea_q.push_back(prev_ea);
               n_acc++;
            end
         end else if (prev_db_v) begin
            check("o_croom_err_v", o_croom_err_v, 1);
            check("o_croom_err_ctxt", o_croom_err_ctxt, prev_ctxt);
            check("o_cmd_dropped", o_cmd_dropped, 0);
            n_rej++;
         end else begin
            check("o_croom_err_v", o_croom_err_v, 0);
            check("o_cmd_dropped", o_cmd_dropped, 0);
         end
         check("o_ctxt_rst_ack", o_ctxt_rst_ack, prev_rst);
         check("o_cmpl_error_hld", o_cmpl_error_hld, err_exp);
         if (cmpl_v) begin
            if (!outst[cmpl_tag]) err_exp = 1'b1;   // sticky from next cycle
            else outst[cmpl_tag] = 1'b0;
         end
         if (db_v) begin
            // a push landing this cycle already counts against the room
            acc_now = exp_accept(mcnt[db_ctxt] + int'(pushed_now && prev_ctxt == db_ctxt),
                                 croom_max);
            n_db++;
         end
         for (int i = 0; i < NUM_CTXT; i++) begin
            if (rst_v && rst_id == ctxt_t'(i)) begin
               mcnt[i] = 0;
            end else if (pushed_now && prev_ctxt == ctxt_t'(i)) begin
               if (!(hs && o_cmd_ctxt == ctxt_t'(i))) mcnt[i]++;
            end else if (hs && o_cmd_ctxt == ctxt_t'(i) && mcnt[i] > 0) begin
               mcnt[i]--;
            end
         end
         prev_db_v = db_v;
         prev_acc  = acc_now;
         prev_ctxt = db_ctxt;
         prev_ea   = db_ea;
         prev_rst  = rst_v;
      end
   end

   task automatic step(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic ring(input ctxt_t c, input ea_t ea);
      db_v    = 1'b1;
      db_ctxt = c;
      db_ea   = ea;
      @(negedge clk);
      db_v = 1'b0;
   endtask

   task automatic free_all();
      for (int i = 0; i < NUM_TAGS; i++) begin
         if (outst[i]) begin
            cmpl_v   = 1'b1;
            cmpl_tag = tag_t'(i);
            @(negedge clk);
            cmpl_v = 1'b0;
         end
      end
   endtask

   task automatic wait_drain();
      step(3);
      while (exp_ctxt_q.size() != 0) @(negedge clk);
      step(2);
   endtask

   initial begin
      void'($urandom(32'h094a8195));
      i_rst_n   = 1'b0;
      db_v      = 1'b0;
      db_ctxt   = '0;
      db_ea     = '0;
      croom_max = 8'd8;
      rst_v     = 1'b0;
      rst_id    = '0;
      cmpl_v    = 1'b0;
      cmpl_tag  = '0;
      cmd_r     = 1'b1;
      cyc       = 0;
      n_db      = 0;
      n_acc     = 0;
      n_rej     = 0;
      n_drop    = 0;
      n_iss     = 0;
      err_exp   = 1'b0;
      prev_db_v = 1'b0;
      prev_acc  = 1'b0;
      prev_rst  = 1'b0;
      prev_ctxt = '0;
      prev_ea   = '0;
      for (int i = 0; i < NUM_CTXT; i++) mcnt[i] = 0;
      for (int i = 0; i < NUM_TAGS; i++) outst[i] = 1'b0;
      repeat (16) @(negedge clk);
      i_rst_n = 1'b1;
      step(2);
      check("o_no_tags", o_no_tags, 0);

      // in-order flow with aligned and misaligned blocks
      for (int i = 0; i < 10; i++) ring(ctxt_t'(i), {48'h1000_0000_ab00, 16'(i * 24)});
      wait_drain();
      free_all();

      // credit limit with the output stalled
      croom_max = 8'd3;
      cmd_r     = 1'b0;
      base_rej  = n_rej;
      for (int i = 0; i < 6; i++) begin
         ring(ctxt_t'(5), 64'h2000 + 64'(i * 16));
         step(1);
      end
      step(3);
      check("rejections", n_rej - base_rej, 3);
      cmd_r = 1'b1;
      wait_drain();
      free_all();

      // context reset restores the room
      cmd_r    = 1'b0;
      base_rej = n_rej;
      base_acc = n_acc;
      for (int i = 0; i < 3; i++) ring(ctxt_t'(6), 64'h3000 + 64'(i * 16));
      step(2);
      rst_v  = 1'b1;
      rst_id = ctxt_t'(6);
      @(negedge clk);
      rst_v = 1'b0;
      step(1);
      for (int i = 0; i < 4; i++) ring(ctxt_t'(6), 64'h3100 + 64'(i * 16));
      step(3);
      check("accepted after reset", n_acc - base_acc, 6);
      check("rejected after reset", n_rej - base_rej, 1);
      cmd_r = 1'b1;
      wait_drain();
      free_all();

      // tag exhaustion without completions
      croom_max = 8'd32;
      base_iss  = n_iss;
      for (int i = 0; i < 20; i++) ring(ctxt_t'(i), 64'h4000 + 64'(i * 16));
      while (n_iss < base_iss + NUM_TAGS) @(negedge clk);
      step(4);
      check("o_no_tags", o_no_tags, 1);
      check("issued without tags", n_iss - base_iss, NUM_TAGS);
      check("queued commands", exp_ctxt_q.size(), 4);
      free_all();
      wait_drain();
      free_all();
      step(2);

      // completion of a free tag is sticky
      cmpl_v   = 1'b1;
      cmpl_tag = tag_t'(3);
      @(negedge clk);
      cmpl_v = 1'b0;
      step(4);
      check("o_cmpl_error_hld", o_cmpl_error_hld, 1);

      // random back-pressure, bursts and completions
      croom_max = 8'd4;
      for (int n = 0; n < 300; n++) begin
         cmd_r   = ($urandom % 4) != 0;
         db_v    = $urandom % 2;
         db_ctxt = ctxt_t'($urandom % 4);
         db_ea   = {$urandom, $urandom};
         cmpl_v  = 1'b0;
         if ($urandom % 3 == 0) begin
            for (int t = NUM_TAGS - 1; t >= 0; t--) begin
               if (outst[t]) begin
                  cmpl_v   = 1'b1;
                  cmpl_tag = tag_t'(t);
               end
            end
         end
         @(negedge clk);
      end
      db_v   = 1'b0;
      cmpl_v = 1'b0;
      cmd_r  = 1'b1;
      // a few rounds of returned tags empty the pipeline
      for (int k = 0; k < 8 && exp_ctxt_q.size() != 0; k++) begin
         free_all();
         step(2);
      end
      step(3);
      check("issued total", n_iss, n_db - n_rej - n_drop);
      check("o_cmpl_error_hld", o_cmpl_error_hld, 1);
      $display("TB PASSED");
      $finish;
   end

endmodule
